// File: source/cnn_pkg.sv
package cnn_pkg;

    localparam int NUM_FILTERS = 3;
    localparam int WIN_PIXELS  = 9;
    localparam int NUM_WINDOWS = 4;    // default that the top level overrides
    localparam int NUM_CLASSES = 4;
    localparam int WEIGHT_W    = 8;
    localparam int FEAT_W      = 6;
    localparam int SCORE_W     = 20;

    // conv weights first, classifier weights from CLASS_BASE on
    localparam int NUM_WEIGHTS = 75;
    localparam int CLASS_BASE  = 27;
    localparam int ADDR_W      = $clog2(NUM_WEIGHTS);

    typedef logic [ADDR_W-1:0] weight_addr_t;
    typedef logic [$clog2(NUM_CLASSES)-1:0] class_idx_t;

    typedef struct packed {
        logic                       we;
        weight_addr_t               addr;
        logic signed [WEIGHT_W-1:0] wdata;
    } mem_req_t;

    // one unsigned feature per filter
    typedef struct packed {
        logic [NUM_FILTERS-1:0][FEAT_W-1:0] feat;
    } feat_vec_t;

    typedef enum logic [1:0] {
        REQ_HOST,
        REQ_CONV,
        REQ_CLASS
    } requester_e;

    typedef enum logic [1:0] {
        CONV_IDLE,
        CONV_FETCH,
        CONV_DRAIN,
        CONV_SEND
    } conv_state_e;

    typedef enum logic [1:0] {
        CLS_WAIT,
        CLS_FETCH,
        CLS_DECIDE
    } class_state_e;

endpackage

// File: source/weight_mem.sv
module weight_mem import cnn_pkg::*; (
    input  logic                       clk_i,
    input  mem_req_t                   req_i,
    output logic signed [WEIGHT_W-1:0] rdata_o
);

    logic signed [WEIGHT_W-1:0] mem [NUM_WEIGHTS];

    always_ff @(posedge clk_i) begin
        if (req_i.we) begin
            mem[req_i.addr] <= req_i.wdata;
        end
        rdata_o <= mem[req_i.addr];    // one cycle read latency
    end

endmodule

// File: source/weight_arbiter.sv
module weight_arbiter import cnn_pkg::*; (
    input  logic         clk_i,
    input  logic         rst,
    input  mem_req_t     host_req_i,
    input  logic         conv_req_i,
    input  weight_addr_t conv_addr_i,
    input  logic         class_req_i,
    input  weight_addr_t class_addr_i,
    output logic         conv_gnt_o,
    output logic         class_gnt_o,
    output mem_req_t     mem_req_o
);

    requester_e last_q;
    logic       host_act;
    logic       conv_pick;

    assign host_act = host_req_i.we;

    // conv wins unless it was the last one served
    assign conv_pick   = conv_req_i && (!class_req_i || last_q != REQ_CONV);
    assign conv_gnt_o  = !host_act && conv_pick;
    assign class_gnt_o = !host_act && class_req_i && !conv_pick;

    always_comb begin
        if (host_act) begin
            mem_req_o = host_req_i;
        end else begin
            mem_req_o.we    = 1'b0;
            mem_req_o.addr  = conv_gnt_o ? conv_addr_i : class_addr_i;
            mem_req_o.wdata = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            last_q <= REQ_CLASS;
        end else if (host_act) begin
            last_q <= REQ_HOST;
        end else if (conv_gnt_o) begin
            last_q <= REQ_CONV;
        end else if (class_gnt_o) begin
            last_q <= REQ_CLASS;
        end
    end

    // weights are only loaded between images
    host_no_overlap: assert property (@(posedge clk_i) disable iff (rst)
        host_req_i.we |-> !(conv_req_i || class_req_i));

endmodule

// File: source/conv_engine.sv
module conv_engine import cnn_pkg::*; #(
    parameter int CREDITS = 2
) (
    input  logic                       clk_i,
    input  logic                       rst,
    input  logic                       win_valid_i,
    input  logic [WIN_PIXELS-1:0]      win_pixels_i,
    output logic                       win_ready_o,
    output logic                       mem_req_o,
    output weight_addr_t               mem_addr_o,
    input  logic                       mem_gnt_i,
    input  logic signed [WEIGHT_W-1:0] mem_rdata_i,
    output logic                       feat_valid_o,
    output feat_vec_t                  feat_o,
    input  logic                       credit_return_i
);

    localparam int TAP_W    = $clog2(WIN_PIXELS);
    localparam int FILT_W   = $clog2(NUM_FILTERS);
    localparam int ACC_W    = WEIGHT_W + TAP_W;
    localparam int CRED_W   = $clog2(CREDITS + 1);
    localparam int FEAT_MAX = 31;

    conv_state_e             state_q;
    logic [WIN_PIXELS-1:0]   pix_q;
    logic [TAP_W-1:0]        tap_q;
    logic [TAP_W-1:0]        pend_tap_q;
    logic [FILT_W-1:0]       filt_q;
    logic [FILT_W-1:0]       pend_filt_q;
    logic                    pend_q;
    logic signed [ACC_W-1:0] acc_q [NUM_FILTERS];
    logic [CRED_W-1:0]       credits_q;
    logic                    accept;
    logic                    grant;
    logic                    last_tap;
    logic                    last_read;
    logic                    send;

    function automatic logic [FEAT_W-1:0] to_feat(input logic signed [ACC_W-1:0] sum);
        logic signed [ACC_W-1:0] shifted;
        shifted = sum >>> 2;
        if (sum < 0) begin
            return '0;
        end
        if (shifted > FEAT_MAX) begin
            return FEAT_W'(FEAT_MAX);
        end
        return FEAT_W'(shifted);
    endfunction

    assign win_ready_o = (state_q == CONV_IDLE);
    assign accept      = win_valid_i && win_ready_o;

    assign mem_req_o  = (state_q == CONV_FETCH);
    assign mem_addr_o = weight_addr_t'(int'(filt_q) * WIN_PIXELS + int'(tap_q));
    assign grant      = mem_req_o && mem_gnt_i;
    assign last_tap   = (tap_q == TAP_W'(WIN_PIXELS - 1));
    assign last_read  = last_tap && (filt_q == FILT_W'(NUM_FILTERS - 1));

    assign send         = (state_q == CONV_SEND) && (credits_q != '0);
    assign feat_valid_o = send;

    always_comb begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            feat_o.feat[f] = to_feat(acc_q[f]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            state_q   <= CONV_IDLE;
            pend_q    <= 1'b0;
            credits_q <= CRED_W'(CREDITS);
        end else begin
            pend_q    <= grant;
            credits_q <= credits_q + CRED_W'(credit_return_i) - CRED_W'(send);
            case (state_q)
                CONV_IDLE:  if (accept) state_q <= CONV_FETCH;
                CONV_FETCH: if (grant && last_read) state_q <= CONV_DRAIN;
                CONV_DRAIN: state_q <= CONV_SEND;    // last weight lands here
                CONV_SEND:  if (send) state_q <= CONV_IDLE;
                default:    state_q <= CONV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            pix_q  <= win_pixels_i;
            tap_q  <= '0;
            filt_q <= '0;
        end else if (grant) begin
            if (last_tap) begin
                tap_q  <= '0;
                filt_q <= filt_q + 1'b1;
            end else begin
                tap_q <= tap_q + 1'b1;
            end
        end
        if (grant) begin
            pend_tap_q  <= tap_q;
            pend_filt_q <= filt_q;
        end
    end

    // add weight only where the pixel is set
    always_ff @(posedge clk_i) begin
        if (accept) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                acc_q[f] <= '0;
            end
        end else if (pend_q && pix_q[pend_tap_q]) begin
            acc_q[pend_filt_q] <= acc_q[pend_filt_q] + mem_rdata_i;
        end
    end

endmodule

// File: source/class_engine.sv
module class_engine import cnn_pkg::*; #(
    parameter int NUM_WINDOWS = cnn_pkg::NUM_WINDOWS,
    parameter int CREDITS     = 2
) (
    input  logic                       clk_i,
    input  logic                       rst,
    input  logic                       feat_valid_i,
    input  feat_vec_t                  feat_i,
    output logic                       credit_return_o,
    output logic                       mem_req_o,
    output weight_addr_t               mem_addr_o,
    input  logic                       mem_gnt_i,
    input  logic signed [WEIGHT_W-1:0] mem_rdata_i,
    output class_idx_t                 class_o,
    output logic                       done_o
);

    localparam int PTR_W  = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W  = $clog2(CREDITS + 1);
    localparam int WIN_W  = (NUM_WINDOWS > 1) ? $clog2(NUM_WINDOWS) : 1;
    localparam int FILT_W = $clog2(NUM_FILTERS);
    localparam int PROD_W = FEAT_W + WEIGHT_W + 1;

    class_state_e              state_q;
    feat_vec_t                 fifo_q [CREDITS];
    logic [PTR_W-1:0]          wr_ptr_q;
    logic [PTR_W-1:0]          rd_ptr_q;
    logic [CNT_W-1:0]          count_q;
    feat_vec_t                 cur_q;
    logic [WIN_W-1:0]          win_q;
    class_idx_t                cls_q;
    class_idx_t                pend_cls_q;
    logic [FILT_W-1:0]         filt_q;
    logic [FILT_W-1:0]         pend_filt_q;
    logic                      issued_q;
    logic                      pend_q;
    logic signed [SCORE_W-1:0] score_q [NUM_CLASSES];
    logic signed [PROD_W-1:0]  prod;
    class_idx_t                best_idx;
    logic                      pop;
    logic                      grant;
    logic                      last_read;
    logic                      last_win;
    logic                      fetch_end;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(CREDITS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop             = (state_q == CLS_WAIT) && (count_q != '0);
    assign credit_return_o = pop;

    assign mem_req_o  = (state_q == CLS_FETCH) && !issued_q;
    assign mem_addr_o = weight_addr_t'(CLASS_BASE
                        + (int'(cls_q) * NUM_WINDOWS + int'(win_q)) * NUM_FILTERS
                        + int'(filt_q));
    assign grant      = mem_req_o && mem_gnt_i;
    assign last_read  = (cls_q == class_idx_t'(NUM_CLASSES - 1))
                        && (filt_q == FILT_W'(NUM_FILTERS - 1));
    assign last_win   = (win_q == WIN_W'(NUM_WINDOWS - 1));
    assign fetch_end  = (state_q == CLS_FETCH) && issued_q && pend_q;

    assign prod = $signed({1'b0, cur_q.feat[pend_filt_q]}) * mem_rdata_i;

    // strict compare keeps the lower index on a tie
    always_comb begin
        best_idx = '0;
        for (int c = 1; c < NUM_CLASSES; c++) begin
            if (score_q[c] > score_q[best_idx]) begin
                best_idx = class_idx_t'(c);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            state_q  <= CLS_WAIT;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            win_q    <= '0;
            issued_q <= 1'b0;
            pend_q   <= 1'b0;
            done_o   <= 1'b0;
            class_o  <= '0;
        end else begin
            pend_q   <= grant;
            done_o   <= (state_q == CLS_DECIDE);
            count_q  <= count_q + CNT_W'(feat_valid_i) - CNT_W'(pop);
            if (feat_valid_i) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            if (grant && last_read) issued_q <= 1'b1;
            case (state_q)
                CLS_WAIT: if (pop) state_q <= CLS_FETCH;
                CLS_FETCH: begin
                    if (fetch_end) begin    // last product accumulates now
                        issued_q <= 1'b0;
                        win_q    <= last_win ? '0 : win_q + 1'b1;
                        state_q  <= last_win ? CLS_DECIDE : CLS_WAIT;
                    end
                end
                CLS_DECIDE: begin
                    class_o <= best_idx;
                    state_q <= CLS_WAIT;
                end
                default: state_q <= CLS_WAIT;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (feat_valid_i) begin
            fifo_q[wr_ptr_q] <= feat_i;
        end
        if (pop) begin
            cur_q  <= fifo_q[rd_ptr_q];
            cls_q  <= '0;
            filt_q <= '0;
        end else if (grant) begin
            if (filt_q == FILT_W'(NUM_FILTERS - 1)) begin
                filt_q <= '0;
                cls_q  <= cls_q + 1'b1;
            end else begin
                filt_q <= filt_q + 1'b1;
            end
        end
        if (grant) begin
            pend_cls_q  <= cls_q;
            pend_filt_q <= filt_q;
        end
    end

    // scores restart with window 0 of each image
    always_ff @(posedge clk_i) begin
        if (pop && win_q == '0) begin
            for (int c = 0; c < NUM_CLASSES; c++) begin
                score_q[c] <= '0;
            end
        end else if (pend_q) begin
            score_q[pend_cls_q] <= score_q[pend_cls_q] + prod;
        end
    end

    // sender must hold a credit for every vector
    fifo_no_overflow: assert property (@(posedge clk_i) disable iff (rst)
        feat_valid_i |-> count_q < CNT_W'(CREDITS));

endmodule

// File: source/cnn_top.sv
module cnn_top import cnn_pkg::*; #(
    parameter int NUM_WINDOWS = cnn_pkg::NUM_WINDOWS,
    parameter int CREDITS     = 2
) (
    input  logic                       clk_i,
    input  logic                       rst,
    input  logic                       wt_we_i,
    input  weight_addr_t               wt_addr_i,
    input  logic signed [WEIGHT_W-1:0] wt_data_i,
    input  logic                       win_valid_i,
    input  logic [WIN_PIXELS-1:0]      win_pixels_i,
    output logic                       win_ready_o,
    output class_idx_t                 class_o,
    output logic                       done_o
);

    mem_req_t                   host_req;
    mem_req_t                   mem_req;
    logic signed [WEIGHT_W-1:0] mem_rdata;
    logic                       conv_req;
    logic                       conv_gnt;
    weight_addr_t               conv_addr;
    logic                       class_req;
    logic                       class_gnt;
    weight_addr_t               class_addr;
    logic                       feat_valid;
    feat_vec_t                  feat;
    logic                       credit_return;

    assign host_req.we    = wt_we_i;
    assign host_req.addr  = wt_addr_i;
    assign host_req.wdata = wt_data_i;

    weight_mem u_mem (
        .clk_i   (clk_i),
        .req_i   (mem_req),
        .rdata_o (mem_rdata)
    );

    weight_arbiter u_arb (
        .clk_i        (clk_i),
        .rst          (rst),
        .host_req_i   (host_req),
        .conv_req_i   (conv_req),
        .conv_addr_i  (conv_addr),
        .class_req_i  (class_req),
        .class_addr_i (class_addr),
        .conv_gnt_o   (conv_gnt),
        .class_gnt_o  (class_gnt),
        .mem_req_o    (mem_req)
    );

    conv_engine #(
        .CREDITS (CREDITS)
    ) u_conv (
        .clk_i           (clk_i),
        .rst             (rst),
        .win_valid_i     (win_valid_i),
        .win_pixels_i    (win_pixels_i),
        .win_ready_o     (win_ready_o),
        .mem_req_o       (conv_req),
        .mem_addr_o      (conv_addr),
        .mem_gnt_i       (conv_gnt),
        .mem_rdata_i     (mem_rdata),
        .feat_valid_o    (feat_valid),
        .feat_o          (feat),
        .credit_return_i (credit_return)
    );

    class_engine #(
        .NUM_WINDOWS (NUM_WINDOWS),
        .CREDITS     (CREDITS)
    ) u_class (
        .clk_i           (clk_i),
        .rst             (rst),
        .feat_valid_i    (feat_valid),
        .feat_i          (feat),
        .credit_return_o (credit_return),
        .mem_req_o       (class_req),
        .mem_addr_o      (class_addr),
        .mem_gnt_i       (class_gnt),
        .mem_rdata_i     (mem_rdata),
        .class_o         (class_o),
        .done_o          (done_o)
    );

endmodule

// File: dv/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic test_reset_state();
    @(negedge clk_i);
    check_value("win_ready_o", int'(win_ready_o), 1);
    check_value("done_o", int'(done_o), 0);
    check_value("class_o", int'(class_o), 0);
    @(posedge clk_i);
endtask

// no pixel set means every score stays zero
task automatic test_zero_pixels();
    image_t img;
    load_random(0, NUM_WEIGHTS - 1);
    for (int w = 0; w < NW; w++) img[w] = '0;
    send_image(img, 1'b0);
    collect_results();
endtask

task automatic test_directed_class2();
    image_t img;
    int     addr;
    for (int a = 0; a < CLASS_BASE; a++) begin
        write_weight(a, WEIGHT_W'(16));    // full window saturates each feature
    end
    for (int c = 0; c < NUM_CLASSES; c++) begin
        for (int w = 0; w < NW; w++) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                addr = CLASS_BASE + (c * NW + w) * NUM_FILTERS + f;
                write_weight(addr, (c == 2) ? WEIGHT_W'(9) : WEIGHT_W'(c - 3));
            end
        end
    end
    end_writes();
    for (int w = 0; w < NW; w++) img[w] = '1;
    send_image(img, 1'b0);
    collect_results();
endtask

task automatic test_random_images();
    image_t img;
    load_random(0, NUM_WEIGHTS - 1);
    repeat (3) begin
        random_image(img);
        send_image(img, 1'b0);
    end
    collect_results();
endtask

// same image before and after new classifier weights
task automatic test_weight_reload();
    image_t img;
    int     first_class;
    int     new_class;
    int     tries;
    load_random(0, NUM_WEIGHTS - 1);
    random_image(img);
    first_class = model_class(img);
    send_image(img, 1'b0);
    collect_results();
    new_class = first_class;
    tries     = 0;
    while (new_class == first_class && tries < RELOAD_TRIES) begin
        load_random(CLASS_BASE, NUM_WEIGHTS - 1);
        new_class = model_class(img);
        tries++;
    end
    checks++;
    assert (new_class != first_class) else begin
        $display("no classifier reload changed the class of the reload image");
        errors++;
    end
    send_image(img, 1'b0);
    collect_results();
endtask

task automatic test_continuous_valid();
    image_t img;
    load_random(0, NUM_WEIGHTS - 1);
    repeat (4) begin
        random_image(img);
        send_image(img, 1'b1);
    end
    win_valid_i <= 1'b0;
    collect_results();
endtask

`endif

// File: dv/tb_cnn.sv
module tb_cnn import cnn_pkg::*; ();

    localparam int NW           = 4;
    localparam int CREDITS      = 2;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int RELOAD_TRIES = 8;
    localparam logic [31:0] SEED = 32'h218be461;

    // each conv read may wait a cycle behind the classifier and the reverse
    localparam int WORST_WIN_CYCLES = 2 * NUM_FILTERS * WIN_PIXELS
                                      + 2 * NUM_CLASSES * NUM_FILTERS + 8;
    localparam int WIN_COUNT        = 11 * NW;    // images over all tests
    localparam int WRITE_COUNT      = 5 * NUM_WEIGHTS
                                      + RELOAD_TRIES * (NUM_WEIGHTS - CLASS_BASE);
    localparam int WATCHDOG_CYCLES  = RESET_CYCLES + 2 * WRITE_COUNT
                                      + WIN_COUNT * WORST_WIN_CYCLES + 200;

    typedef logic [WIN_PIXELS-1:0] image_t [NW];

    logic                       clk_i;
    logic                       rst;
    logic                       wt_we_i;
    weight_addr_t               wt_addr_i;
    logic signed [WEIGHT_W-1:0] wt_data_i;
    logic                       win_valid_i;
    logic [WIN_PIXELS-1:0]      win_pixels_i;
    logic                       win_ready_o;
    class_idx_t                 class_o;
    logic                       done_o;

    logic [31:0] lfsr_q;
    int          weights_model [NUM_WEIGHTS];
    int          expected [$];
    int          results [$];
    int          errors;
    int          checks;
    int          tests_run;
    int          test_err_base;

    cnn_top #(
        .NUM_WINDOWS (NW),
        .CREDITS     (CREDITS)
    ) u_dut (
        .clk_i        (clk_i),
        .rst          (rst),
        .wt_we_i      (wt_we_i),
        .wt_addr_i    (wt_addr_i),
        .wt_data_i    (wt_data_i),
        .win_valid_i  (win_valid_i),
        .win_pixels_i (win_pixels_i),
        .win_ready_o  (win_ready_o),
        .class_o      (class_o),
        .done_o       (done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    // results sampled mid-cycle
    always @(negedge clk_i) begin
        if (!rst && done_o) begin
            results.push_back(int'(class_o));
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            val    = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    // clamp at 0, divide by 4, saturate at 31
    function automatic int feature(input logic [WIN_PIXELS-1:0] pix, input int f);
        int sum;
        sum = 0;
        for (int k = 0; k < WIN_PIXELS; k++) begin
            if (pix[k]) sum += weights_model[f * WIN_PIXELS + k];
        end
        if (sum < 0) return 0;
        sum = sum / 4;
        return (sum > 31) ? 31 : sum;
    endfunction

    function automatic int model_class(input image_t img);
        int score [NUM_CLASSES];
        int fv;
        int best;
        for (int c = 0; c < NUM_CLASSES; c++) score[c] = 0;
        for (int w = 0; w < NW; w++) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                fv = feature(img[w], f);
                for (int c = 0; c < NUM_CLASSES; c++) begin
                    score[c] += fv * weights_model[CLASS_BASE + (c * NW + w) * NUM_FILTERS + f];
                end
            end
        end
        best = 0;
        for (int c = 1; c < NUM_CLASSES; c++) begin
            if (score[c] > score[best]) best = c;    // tie keeps lower index
        end
        return best;
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic write_weight(input int addr, input logic signed [WEIGHT_W-1:0] data);
        wt_we_i   <= 1'b1;
        wt_addr_i <= weight_addr_t'(addr);
        wt_data_i <= data;
        weights_model[addr] = int'(data);
        @(posedge clk_i);
    endtask

    task automatic end_writes();
        wt_we_i <= 1'b0;
        @(posedge clk_i);
    endtask

    task automatic load_random(input int lo, input int hi);
        for (int a = lo; a <= hi; a++) begin
            write_weight(a, WEIGHT_W'(take_bits(WEIGHT_W)));
        end
        end_writes();
    endtask

    task automatic random_image(output image_t img);
        for (int w = 0; w < NW; w++) img[w] = WIN_PIXELS'(take_bits(WIN_PIXELS));
    endtask

    task automatic drive_window(input logic [WIN_PIXELS-1:0] pix);
        logic taken;
        win_valid_i  <= 1'b1;
        win_pixels_i <= pix;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            taken = win_ready_o;    // holds until the next edge
            @(posedge clk_i);
        end
    endtask

    task automatic send_image(input image_t img, input logic continuous);
        expected.push_back(model_class(img));
        for (int w = 0; w < NW; w++) begin
            drive_window(img[w]);
            if (!continuous) begin
                win_valid_i <= 1'b0;
                @(posedge clk_i);
            end
        end
    endtask

    task automatic collect_results();
        int limit;
        int waited;
        int n;
        limit  = expected.size() * NW * WORST_WIN_CYCLES;
        waited = 0;
        while (results.size() < expected.size() && waited < limit) begin
            @(posedge clk_i);
            waited++;
        end
        checks++;
        assert (results.size() >= expected.size()) else begin
            $display("done_o did not pulse for every image within %0d cycles", limit);
            errors++;
        end
        repeat (4) @(posedge clk_i);    // catch stray pulses
        check_value("done_o pulses", results.size(), expected.size());
        n = (results.size() < expected.size()) ? results.size() : expected.size();
        for (int i = 0; i < n; i++) check_value("class_o", results[i], expected[i]);
        results.delete();
        expected.delete();
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("%s: %s", name, (errors == test_err_base) ? "ok" : "failed");
        test_err_base = errors;
    endtask

    `include "tb_tasks.svh"

    initial begin
        rst           = 1'b1;
        wt_we_i       = 1'b0;
        wt_addr_i     = '0;
        wt_data_i     = '0;
        win_valid_i   = 1'b0;
        win_pixels_i  = '0;
        lfsr_q        = SEED;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        test_err_base = 0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst <= 1'b0;
        @(posedge clk_i);
        test_reset_state();
        report_test("reset_state");
        test_zero_pixels();
        report_test("zero_pixels");
        test_directed_class2();
        report_test("directed_class2");
        test_random_images();
        report_test("random_images");
        test_weight_reload();
        report_test("weight_reload");
        test_continuous_valid();
        report_test("continuous_valid");
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+dv
source/cnn_pkg.sv
source/weight_mem.sv
source/weight_arbiter.sv
source/conv_engine.sv
source/class_engine.sv
source/cnn_top.sv
dv/tb_cnn.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cnn -f sim.f -o tb_cnn

./obj_dir/tb_cnn | tee sim.log

grep -q "All tests passed" sim.log
echo "simulation passed"
